// ==== Bender.yml ====
package:
  name: sprite_engine

sources:
  - sprite_pkg.sv
  - sprite_ram.sv
  - sprite_attr_table.sv
  - scanline_buffer.sv
  - sprite_renderer.sv
  - sprite_engine.sv
  - target: simulation
    files:
      - sprite_engine_properties.sv
      - sprite_checker.sv
      - tb_sprite_engine.sv

// ==== scanline_buffer.sv ====
`timescale 1ns/1ps

module scanline_buffer #(
	parameter int LINE_PIXELS = 800
) (
	input  logic                              CLK,
	input  logic                              RSTb,
	input  logic                              H_tick,
	input  logic [sprite_pkg::COORD_BITS-1:0] display_x,
	output logic [sprite_pkg::COLOR_BITS-1:0] color_index,
	input  logic                              draw_wr,
	input  logic [sprite_pkg::COORD_BITS-1:0] draw_x,
	input  logic [sprite_pkg::COLOR_BITS-1:0] draw_color
);
	import sprite_pkg::*;

	logic                  back_sel;
	logic                  front_q;
	logic [COORD_BITS-1:0] clear_x;
	logic [COLOR_BITS-1:0] rd_data [2];

	// Back buffer is rendered, the other one is on display
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			back_sel <= 1'b0;
			front_q  <= 1'b1;
		end else begin
			if (H_tick) begin
				back_sel <= ~back_sel;
			end
			// Buffer whose read data appears this cycle
			front_q <= ~back_sel;
		end
	end

	// Erase the pixel shown on the previous clock
	assign clear_x = (display_x == '0) ? COORD_BITS'(LINE_PIXELS - 1) : display_x - 1'b1;

	for (genvar i = 0; i < 2; i++) begin : g_line
		logic                  is_back;
		logic                  wr_en;
		logic [COORD_BITS-1:0] wr_addr;
		logic [COLOR_BITS-1:0] wr_data;

		assign is_back = (back_sel == 1'(i));
		assign wr_en   = is_back ? draw_wr : 1'b1;
		assign wr_addr = is_back ? draw_x : clear_x;
		assign wr_data = is_back ? draw_color : '0;

		sprite_ram #(
			.DATA_BITS(COLOR_BITS),
			.ADDR_BITS(COORD_BITS)
		) line_ram (
			.CLK(CLK),
			.rd_addr(display_x),
			.rd_data(rd_data[i]),
			.wr_addr(wr_addr),
			.wr_data(wr_data),
			.wr(wr_en)
		);
	end

	assign color_index = rd_data[front_q];

endmodule

// ==== sim.f ====
sprite_pkg.sv
sprite_ram.sv
sprite_attr_table.sv
scanline_buffer.sv
sprite_renderer.sv
sprite_engine.sv
sprite_engine_properties.sv
sprite_checker.sv
tb_sprite_engine.sv

// ==== sprite_attr_table.sv ====
`timescale 1ns/1ps

module sprite_attr_table #(
	parameter int NUM_SPRITES = 256
) (
	input  logic                              CLK,
	input  logic [9:0]                        ADDRESS,
	input  logic [sprite_pkg::WORD_BITS-1:0]  DATA_IN,
	input  logic                              WR,
	input  logic [$clog2(NUM_SPRITES)-1:0]    sprite_index,
	output logic [sprite_pkg::WORD_BITS-1:0]  x_word,
	output logic [sprite_pkg::WORD_BITS-1:0]  y_word,
	output logic [sprite_pkg::WORD_BITS-1:0]  h_word,
	output logic [sprite_pkg::WORD_BITS-1:0]  a_word
);
	import sprite_pkg::*;

	localparam int IDX_BITS = $clog2(NUM_SPRITES);

	attr_sel_t            sel;
	logic [3:0]           ram_wr;
	logic [WORD_BITS-1:0] ram_out [4];

	assign sel = attr_sel_t'(ADDRESS[9:8]);

	// One strobe per attribute RAM
	always_comb begin
		ram_wr      = '0;
		ram_wr[sel] = WR;
	end

	for (genvar i = 0; i < 4; i++) begin : g_attr
		sprite_ram #(
			.DATA_BITS(WORD_BITS),
			.ADDR_BITS(IDX_BITS)
		) attr_ram (
			.CLK(CLK),
			.rd_addr(sprite_index),
			.rd_data(ram_out[i]),
			.wr_addr(ADDRESS[IDX_BITS-1:0]),
			.wr_data(DATA_IN),
			.wr(ram_wr[i])
		);
	end

	assign x_word = ram_out[sel_x];
	assign y_word = ram_out[sel_y];
	assign h_word = ram_out[sel_h];
	assign a_word = ram_out[sel_a];

endmodule

// ==== sprite_checker.sv ====
`timescale 1ns/1ps

module sprite_checker #(
	parameter int NUM_SPRITES = 16,
	parameter int LINE_PIXELS = 800
) (
	input logic                              CLK,
	input logic                              sweeping,
	input logic [sprite_pkg::COORD_BITS-1:0] display_x,
	input logic [sprite_pkg::COLOR_BITS-1:0] color_index
);
	import sprite_pkg::*;

	bit   [WORD_BITS-1:0]  attr [4][NUM_SPRITES];
	bit   [WORD_BITS-1:0]  sheet [2**MEM_ADDR_BITS];
	logic [COLOR_BITS-1:0] expected [LINE_PIXELS];
	logic [COLOR_BITS-1:0] observed [LINE_PIXELS];
	logic                  valid_q = 1'b0;
	logic [COORD_BITS-1:0] x_q;
	int                    errors = 0;

	task automatic note_attr(input int addr, input int data);
		attr[(addr >> 8) % 4][addr % NUM_SPRITES] = 16'(data);
	endtask

	task automatic note_sheet(input int addr, input int data);
		sheet[addr % 65536] = 16'(data);
	endtask

	task automatic clear_line();
		for (int x = 0; x < LINE_PIXELS; x++) begin
			expected[x] = '0;
		end
	endtask

	// Expected line from the attribute rules, later sprites on top
	task automatic build_line(input int y);
		bit   [WORD_BITS-1:0]  xw;
		bit   [WORD_BITS-1:0]  yw;
		bit   [WORD_BITS-1:0]  hw;
		bit   [WORD_BITS-1:0]  aw;
		bit   [WORD_BITS-1:0]  word;
		bit   [4:0]            pix;
		logic [COLOR_BITS-1:0] col;
		int                    v;
		int                    row;
		int                    ppw;
		int                    px;
		clear_line();
		for (int s = 0; s < NUM_SPRITES; s++) begin
			xw = attr[0][s];
			yw = attr[1][s];
			hw = attr[2][s];
			aw = attr[3][s];
			if (xw[X_ENABLE_BIT] && y >= int'(yw[Y_START_MSB:Y_START_LSB]) &&
					y <= int'(hw[H_END_MSB:H_END_LSB])) begin
				v   = y - int'(yw[Y_START_MSB:Y_START_LSB]);
				row = xw[X_STRIDE_BIT] ? 64 : 80;
				ppw = hw[H_DEPTH_BIT] ? 3 : 4;
				for (int p = 0; p <= int'(yw[Y_WIDTH_MSB:Y_WIDTH_LSB]); p++) begin
					word = sheet[(int'(aw) + v * row + p / ppw) % 65536];
					px   = int'(xw[X_COORD_MSB:X_COORD_LSB]) + p;
					if (ppw == 3) begin
						pix = 5'(word >> (5 * (p % 3)));
						col = {xw[X_PAL_MSB:X_PAL_LSB+1], pix};
					end else begin
						pix = {1'b0, 4'(word >> (4 * (p % 4)))};
						col = {xw[X_PAL_MSB:X_PAL_LSB], pix[3:0]};
					end
					if (pix != '0 && px < LINE_PIXELS) begin
						expected[px] = col;
					end
				end
			end
		end
	endtask

	// Pixel listed in the data file against what the sweep showed
	task automatic check_spot(input int x, input int color);
		if (observed[x] !== COLOR_BITS'(color)) begin
			errors++;
			$display("[ERROR] color_index at x=%h: got %h, listed %h",
				x, observed[x], COLOR_BITS'(color));
		end
	endtask

	// color_index answers the display_x of the previous clock
	always @(posedge CLK) begin
		if (valid_q) begin
			observed[x_q] = color_index;
			if (color_index !== expected[x_q]) begin
				errors++;
				$display("[ERROR] color_index at x=%h: got %h, expected %h",
					x_q, color_index, expected[x_q]);
			end
		end
		valid_q <= sweeping;
		x_q     <= display_x;
	end

endmodule

// ==== sprite_engine.sv ====
`timescale 1ns/1ps

module sprite_engine #(
	parameter int NUM_SPRITES = 256,
	parameter int LINE_PIXELS = 800
) (
	input  logic                                 CLK,
	input  logic                                 RSTb,
	input  logic [9:0]                           ADDRESS,
	input  logic [sprite_pkg::WORD_BITS-1:0]     DATA_IN,
	input  logic                                 WR,
	input  logic                                 H_tick,
	input  logic [sprite_pkg::COORD_BITS-1:0]    display_x,
	input  logic [sprite_pkg::COORD_BITS-1:0]    display_y,
	output logic [sprite_pkg::COLOR_BITS-1:0]    color_index,
	output logic [sprite_pkg::MEM_ADDR_BITS-1:0] memory_address,
	input  logic [sprite_pkg::WORD_BITS-1:0]     memory_data,
	output logic                                 rvalid,
	input  logic                                 rready
);
	import sprite_pkg::*;

	localparam int IDX_BITS = $clog2(NUM_SPRITES);

	logic [IDX_BITS-1:0]   sprite_index;
	logic [WORD_BITS-1:0]  x_word;
	logic [WORD_BITS-1:0]  y_word;
	logic [WORD_BITS-1:0]  h_word;
	logic [WORD_BITS-1:0]  a_word;
	logic                  draw_wr;
	logic [COORD_BITS-1:0] draw_x;
	logic [COLOR_BITS-1:0] draw_color;

	sprite_attr_table #(
		.NUM_SPRITES(NUM_SPRITES)
	) attr_table_inst (
		.CLK(CLK),
		.ADDRESS(ADDRESS),
		.DATA_IN(DATA_IN),
		.WR(WR),
		.sprite_index(sprite_index),
		.x_word(x_word),
		.y_word(y_word),
		.h_word(h_word),
		.a_word(a_word)
	);

	sprite_renderer #(
		.NUM_SPRITES(NUM_SPRITES)
	) renderer_inst (
		.CLK(CLK),
		.RSTb(RSTb),
		.H_tick(H_tick),
		.display_y(display_y),
		.sprite_index(sprite_index),
		.x_word(x_word),
		.y_word(y_word),
		.h_word(h_word),
		.a_word(a_word),
		.memory_address(memory_address),
		.memory_data(memory_data),
		.rvalid(rvalid),
		.rready(rready),
		.draw_wr(draw_wr),
		.draw_x(draw_x),
		.draw_color(draw_color)
	);

	scanline_buffer #(
		.LINE_PIXELS(LINE_PIXELS)
	) scanline_inst (
		.CLK(CLK),
		.RSTb(RSTb),
		.H_tick(H_tick),
		.display_x(display_x),
		.color_index(color_index),
		.draw_wr(draw_wr),
		.draw_x(draw_x),
		.draw_color(draw_color)
	);

endmodule

// ==== sprite_engine_properties.sv ====
`timescale 1ns/1ps

module sprite_engine_properties (
	input logic                                 CLK,
	input logic                                 RSTb,
	input logic                                 H_tick,
	input logic                                 rvalid,
	input logic                                 rready,
	input logic [sprite_pkg::MEM_ADDR_BITS-1:0] memory_address,
	input logic                                 draw_wr,
	input logic [3:0]                           state
);
	import sprite_pkg::*;

	logic ticked;
	int   fail_count = 0;

	// Set by the first line start after reset
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			ticked <= 1'b0;
		end else if (H_tick) begin
			ticked <= 1'b1;
		end
	end

	// Request holds until the memory answers, unless a line start aborts it
	request_held: assert property (@(posedge CLK) disable iff (!RSTb)
		rvalid && !rready && !H_tick |=> rvalid && $stable(memory_address))
		else begin
			fail_count++;
			$error("rvalid dropped or memory_address moved before rready");
		end

	no_early_draw: assert property (@(posedge CLK) disable iff (!RSTb)
		!ticked |-> !draw_wr)
		else begin
			fail_count++;
			$error("draw write before the first H_tick");
		end

	state_legal: assert property (@(posedge CLK) disable iff (!RSTb)
		state <= 4'(r_finish))
		else begin
			fail_count++;
			$error("renderer state %h outside the state enum", state);
		end

endmodule

bind sprite_renderer sprite_engine_properties props_inst (
	.CLK(CLK),
	.RSTb(RSTb),
	.H_tick(H_tick),
	.rvalid(rvalid),
	.rready(rready),
	.memory_address(memory_address),
	.draw_wr(draw_wr),
	.state(state)
);

// ==== sprite_pkg.sv ====
package sprite_pkg;

	// Bus and pixel widths
	localparam int COORD_BITS    = 10;
	localparam int COLOR_BITS    = 8;
	localparam int MEM_ADDR_BITS = 16;
	localparam int WORD_BITS     = 16;

	// X word
	localparam int X_COORD_LSB  = 0;
	localparam int X_COORD_MSB  = 9;
	localparam int X_ENABLE_BIT = 10;
	localparam int X_PAL_LSB    = 11;
	localparam int X_PAL_MSB    = 14;
	localparam int X_STRIDE_BIT = 15;

	// Y word
	localparam int Y_START_LSB = 0;
	localparam int Y_START_MSB = 9;
	localparam int Y_WIDTH_LSB = 10;
	localparam int Y_WIDTH_MSB = 15;

	// H word, depth bit set means 5 bpp
	localparam int H_END_LSB   = 0;
	localparam int H_END_MSB   = 9;
	localparam int H_DEPTH_BIT = 15;

	// Sheet words per row for stride select 0 and 1
	localparam logic [MEM_ADDR_BITS-1:0] ROW_WORDS_WIDE   = 16'd80;
	localparam logic [MEM_ADDR_BITS-1:0] ROW_WORDS_NARROW = 16'd64;

	typedef enum logic [3:0] {
		r_idle,
		r_begin,
		r_load_regs,
		r_load_addr,
		r_request,
		r_wait_data,
		r_blit4_0,
		r_blit4_1,
		r_blit4_2,
		r_blit4_3,
		r_blit5_0,
		r_blit5_1,
		r_blit5_2,
		r_finish
	} render_state_t;

	// Host address bits 9:8
	typedef enum logic [1:0] {
		sel_x = 2'd0,
		sel_y = 2'd1,
		sel_h = 2'd2,
		sel_a = 2'd3
	} attr_sel_t;

endpackage

// ==== sprite_ram.sv ====
`timescale 1ns/1ps

module sprite_ram #(
	parameter int DATA_BITS = 16,
	parameter int ADDR_BITS = 8
) (
	input  logic                 CLK,
	input  logic [ADDR_BITS-1:0] rd_addr,
	output logic [DATA_BITS-1:0] rd_data,
	input  logic [ADDR_BITS-1:0] wr_addr,
	input  logic [DATA_BITS-1:0] wr_data,
	input  logic                 wr
);

	logic [DATA_BITS-1:0] mem [2**ADDR_BITS];

	// Blank contents at configuration
	initial begin
		for (int i = 0; i < 2**ADDR_BITS; i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge CLK) begin
		if (wr) begin
			mem[wr_addr] <= wr_data;
		end
		// Old data on a same-address collision
		rd_data <= mem[rd_addr];
	end

endmodule

// ==== sprite_renderer.sv ====
`timescale 1ns/1ps

module sprite_renderer #(
	parameter int NUM_SPRITES = 256
) (
	input  logic                                 CLK,
	input  logic                                 RSTb,
	input  logic                                 H_tick,
	input  logic [sprite_pkg::COORD_BITS-1:0]    display_y,
	output logic [$clog2(NUM_SPRITES)-1:0]       sprite_index,
	input  logic [sprite_pkg::WORD_BITS-1:0]     x_word,
	input  logic [sprite_pkg::WORD_BITS-1:0]     y_word,
	input  logic [sprite_pkg::WORD_BITS-1:0]     h_word,
	input  logic [sprite_pkg::WORD_BITS-1:0]     a_word,
	output logic [sprite_pkg::MEM_ADDR_BITS-1:0] memory_address,
	input  logic [sprite_pkg::WORD_BITS-1:0]     memory_data,
	output logic                                 rvalid,
	input  logic                                 rready,
	output logic                                 draw_wr,
	output logic [sprite_pkg::COORD_BITS-1:0]    draw_x,
	output logic [sprite_pkg::COLOR_BITS-1:0]    draw_color
);
	import sprite_pkg::*;

	localparam int IDX_BITS   = $clog2(NUM_SPRITES);
	localparam int COUNT_BITS = Y_WIDTH_MSB - Y_WIDTH_LSB + 1;

	render_state_t state;

	logic [COORD_BITS-1:0]        cur_x;
	logic [COORD_BITS-1:0]        cur_v;
	logic [X_PAL_MSB-X_PAL_LSB:0] palette;
	logic [COUNT_BITS-1:0]        pix_count;
	logic [MEM_ADDR_BITS-1:0]     word_offset;
	logic [WORD_BITS-1:0]         word_data;

	logic [COORD_BITS-1:0]    y_start;
	logic [COORD_BITS-1:0]    y_end;
	logic [COUNT_BITS-1:0]    width_m1;
	logic                     on_line;
	logic                     last_sprite;
	logic                     last_pixel;
	logic [MEM_ADDR_BITS-1:0] v_ext;
	logic [MEM_ADDR_BITS-1:0] row_offset;
	logic                     is_blit;
	logic                     is_blit5;
	logic                     last_in_word;
	logic [4:0]               pixel;

	// Attribute fields, valid from the load state onwards
	assign y_start  = y_word[Y_START_MSB:Y_START_LSB];
	assign y_end    = h_word[H_END_MSB:H_END_LSB];
	assign width_m1 = y_word[Y_WIDTH_MSB:Y_WIDTH_LSB];
	assign on_line  = x_word[X_ENABLE_BIT] && (display_y >= y_start) && (display_y <= y_end);

	assign last_sprite = (sprite_index == IDX_BITS'(NUM_SPRITES - 1));
	assign last_pixel  = (pix_count == width_m1);

	// Sheet row start relative to the sprite base
	assign v_ext      = MEM_ADDR_BITS'(cur_v);
	assign row_offset = x_word[X_STRIDE_BIT] ? v_ext * ROW_WORDS_NARROW : v_ext * ROW_WORDS_WIDE;

	// Pixel unpack, low bits first
	always_comb begin
		is_blit      = 1'b1;
		is_blit5     = 1'b0;
		last_in_word = 1'b0;
		pixel        = '0;
		case (state)
			r_blit4_0: pixel = {1'b0, word_data[3:0]};
			r_blit4_1: pixel = {1'b0, word_data[7:4]};
			r_blit4_2: pixel = {1'b0, word_data[11:8]};
			r_blit4_3: begin
				pixel        = {1'b0, word_data[15:12]};
				last_in_word = 1'b1;
			end
			r_blit5_0: begin
				pixel    = word_data[4:0];
				is_blit5 = 1'b1;
			end
			r_blit5_1: begin
				pixel    = word_data[9:5];
				is_blit5 = 1'b1;
			end
			r_blit5_2: begin
				// Bit 15 carries no pixel
				pixel        = word_data[14:10];
				is_blit5     = 1'b1;
				last_in_word = 1'b1;
			end
			default: is_blit = 1'b0;
		endcase

		// Zero is transparent
		draw_wr    = is_blit && (pixel != '0);
		draw_color = is_blit5 ? {palette[3:1], pixel} : {palette, pixel[3:0]};
	end

	assign draw_x = cur_x;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state        <= r_idle;
			sprite_index <= '0;
			rvalid       <= 1'b0;
		end else if (H_tick) begin
			// New line restarts from sprite 0
			state        <= r_begin;
			sprite_index <= '0;
			rvalid       <= 1'b0;
		end else begin
			case (state)
				r_begin: state <= r_load_regs;
				r_load_regs: state <= on_line ? r_load_addr : r_finish;
				r_load_addr: state <= r_request;
				r_request: begin
					rvalid <= 1'b1;
					state  <= r_wait_data;
				end
				r_wait_data: begin
					if (rready) begin
						rvalid <= 1'b0;
						state  <= h_word[H_DEPTH_BIT] ? r_blit5_0 : r_blit4_0;
					end
				end
				r_blit4_0, r_blit4_1, r_blit4_2, r_blit4_3,
				r_blit5_0, r_blit5_1, r_blit5_2: begin
					if (last_pixel) begin
						state <= r_finish;
					end else if (last_in_word) begin
						state <= r_load_addr;
					end else begin
						state <= render_state_t'(state + 4'd1);
					end
				end
				r_finish: begin
					sprite_index <= sprite_index + 1'b1;
					state        <= last_sprite ? r_idle : r_begin;
				end
				default: state <= r_idle;
			endcase
		end
	end

	// Per-sprite working registers
	always_ff @(posedge CLK) begin
		case (state)
			r_load_regs: begin
				cur_x       <= x_word[X_COORD_MSB:X_COORD_LSB];
				cur_v       <= display_y - y_start;
				palette     <= x_word[X_PAL_MSB:X_PAL_LSB];
				pix_count   <= '0;
				word_offset <= '0;
			end
			r_load_addr: memory_address <= a_word + row_offset + word_offset;
			r_wait_data: begin
				if (rready) begin
					word_data <= memory_data;
				end
			end
			default: begin
				if (is_blit) begin
					cur_x     <= cur_x + 1'b1;
					pix_count <= pix_count + 1'b1;
					if (last_in_word) begin
						word_offset <= word_offset + 1'b1;
					end
				end
			end
		endcase
	end

endmodule

// ==== sprite_tests.txt ====
# kind arg_a arg_b in hex, W host write of address and data, M sheet word address and data
# P expected x and color for the next line case, L display_y and cycle budget, R sweep only
W 000 2C64
W 100 1C0A
W 200 0014
W 300 1000
W 001 DD2C
W 101 1028
W 201 8032
W 301 2000
W 002 3864
W 102 1C0A
W 202 0014
W 302 1000
W 003 15F4
W 103 0C46
W 203 0046
W 303 3000
W 004 CDF6
W 104 0C44
W 204 0048
W 304 4000
M 10A0 3021
M 10A1 F0A4
M 20C0 FC11
M 20C1 0145
M 3000 4321
M 4080 50E0
P 064 51
P 066 00
P 06B 5F
L 00C 0C8
P 12C B1
P 12D 00
P 12E BF
P 130 AA
L 02B 0C8
P 064 00
L 015 0C8
P 12C 00
L 005 0C8
P 1F4 21
P 1F6 23
P 1F7 9E
P 1F8 00
P 1F9 95
L 046 0C8
P 1F7 00
R 000 000

// ==== tb_sprite_engine.sv ====
`timescale 1ns/1ps

module tb_sprite_engine;
	import sprite_pkg::*;

	localparam int NUM_SPRITES  = 16;
	localparam int LINE_PIXELS  = 800;
	localparam int SETUP_CYCLES = 200;

	logic                     CLK = 1'b0;
	logic                     RSTb;
	logic [9:0]               ADDRESS;
	logic [WORD_BITS-1:0]     DATA_IN;
	logic                     WR;
	logic                     H_tick;
	logic [COORD_BITS-1:0]    display_x;
	logic [COORD_BITS-1:0]    display_y;
	logic [COLOR_BITS-1:0]    color_index;
	logic [MEM_ADDR_BITS-1:0] memory_address;
	logic [WORD_BITS-1:0]     memory_data;
	logic                     rvalid;
	logic                     rready;
	logic                     sweeping = 1'b0;

	bit [WORD_BITS-1:0] sheet [2**MEM_ADDR_BITS];
	byte                kinds[$];
	int                 arg_a[$];
	int                 arg_b[$];
	integer             seed = 57742;
	int                 tb_errors = 0;
	int                 cycles = 0;
	int                 limit = 0;

	always #20 CLK = ~CLK;

	sprite_engine #(
		.NUM_SPRITES(NUM_SPRITES),
		.LINE_PIXELS(LINE_PIXELS)
	) sprite_engine_inst (
		.CLK(CLK),
		.RSTb(RSTb),
		.ADDRESS(ADDRESS),
		.DATA_IN(DATA_IN),
		.WR(WR),
		.H_tick(H_tick),
		.display_x(display_x),
		.display_y(display_y),
		.color_index(color_index),
		.memory_address(memory_address),
		.memory_data(memory_data),
		.rvalid(rvalid),
		.rready(rready)
	);

	sprite_checker #(
		.NUM_SPRITES(NUM_SPRITES),
		.LINE_PIXELS(LINE_PIXELS)
	) checker_inst (
		.CLK(CLK),
		.sweeping(sweeping),
		.display_x(display_x),
		.color_index(color_index)
	);

	// Sheet memory with 0 to 5 cycles of latency
	initial begin : memory_model
		int delay;
		rready      = 1'b0;
		memory_data = '0;
		forever begin
			@(posedge CLK);
			if (rvalid) begin
				delay = $unsigned($random(seed)) % 6;
				repeat (delay) @(posedge CLK);
				#2;
				if (rvalid) begin
					rready      = 1'b1;
					memory_data = sheet[memory_address];
					@(posedge CLK);
					#2;
					rready = 1'b0;
				end
			end
		end
	end

	always @(posedge CLK) begin
		cycles++;
		if (limit > 0 && cycles > limit) begin
			$display("Timeout after %0d cycles, the run did not finish", limit);
			$display("*** FAILED ***");
			$finish;
		end
	end

	task automatic host_write(input int addr, input int data);
		@(posedge CLK);
		#2;
		ADDRESS = 10'(addr);
		DATA_IN = 16'(data);
		WR      = 1'b1;
		@(posedge CLK);
		#2;
		WR = 1'b0;
		checker_inst.note_attr(addr, data);
	endtask

	task automatic pulse_tick();
		@(posedge CLK);
		#2;
		H_tick = 1'b1;
		@(posedge CLK);
		#2;
		H_tick = 1'b0;
	endtask

	// Render into the back buffer, then bring it to the front
	task automatic render_line(input int y, input int budget);
		int waited;
		display_y = COORD_BITS'(y);
		checker_inst.build_line(y);
		pulse_tick();
		waited = 0;
		while (sprite_engine_inst.renderer_inst.state != r_idle && waited < budget) begin
			@(posedge CLK);
			#2;
			waited++;
		end
		if (sprite_engine_inst.renderer_inst.state != r_idle) begin
			tb_errors++;
			$display("Renderer still busy on line %0d after %0d cycles", y, budget);
		end
		pulse_tick();
	endtask

	task automatic sweep_line();
		for (int x = 0; x < LINE_PIXELS; x++) begin
			@(posedge CLK);
			#2;
			display_x = COORD_BITS'(x);
			sweeping  = 1'b1;
		end
		@(posedge CLK);
		#2;
		sweeping  = 1'b0;
		display_x = '0;
		repeat (2) @(posedge CLK);
		#2;
	endtask

	initial begin : main
		int    fd;
		int    n;
		int    a;
		int    b;
		int    total;
		string tag;
		string text;
		int    spot_x[$];
		int    spot_c[$];
		RSTb      = 1'b0;
		ADDRESS   = '0;
		DATA_IN   = '0;
		WR        = 1'b0;
		H_tick    = 1'b0;
		display_x = '0;
		display_y = '0;

		fd = $fopen("sprite_tests.txt", "r");
		if (fd == 0) begin
			tb_errors++;
			$display("Could not open sprite_tests.txt");
		end else begin
			while (!$feof(fd)) begin
				text = "";
				n = $fgets(text, fd);
				n = $sscanf(text, "%s %h %h", tag, a, b);
				if (n == 3 && tag != "#") begin
					kinds.push_back(tag.getc(0));
					arg_a.push_back(a);
					arg_b.push_back(b);
				end
			end
			$fclose(fd);
		end

		// Two sweeps worth of cycles plus the render budget per line case
		foreach (kinds[i]) begin
			if (kinds[i] == "L" || kinds[i] == "R") begin
				limit += 2 * LINE_PIXELS + arg_b[i];
			end else if (kinds[i] == "W") begin
				limit += 2;
			end
		end
		limit += SETUP_CYCLES;

		repeat (5) @(posedge CLK);
		#2;
		RSTb = 1'b1;

		foreach (kinds[i]) begin
			case (kinds[i])
				"W": host_write(arg_a[i], arg_b[i]);
				"M": begin
					sheet[arg_a[i] % 65536] = 16'(arg_b[i]);
					checker_inst.note_sheet(arg_a[i], arg_b[i]);
				end
				"P": begin
					spot_x.push_back(arg_a[i]);
					spot_c.push_back(arg_b[i]);
				end
				"L": begin
					render_line(arg_a[i], arg_b[i]);
					sweep_line();
				end
				"R": begin
					// Same front buffer again with no render in between
					checker_inst.clear_line();
					sweep_line();
				end
				default: begin
					tb_errors++;
					$display("Unknown record kind in sprite_tests.txt");
				end
			endcase
			if (kinds[i] == "L" || kinds[i] == "R") begin
				foreach (spot_x[j]) begin
					checker_inst.check_spot(spot_x[j], spot_c[j]);
				end
				spot_x.delete();
				spot_c.delete();
			end
		end

		total = tb_errors + checker_inst.errors +
			sprite_engine_inst.renderer_inst.props_inst.fail_count;
		$display("Errors: %0d pixel, %0d run, %0d assertion", checker_inst.errors, tb_errors,
			sprite_engine_inst.renderer_inst.props_inst.fail_count);
		if (total == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule
